//--- sat_pkg.sv
/*
  shared definitions for the SAT state list
    level and bin id widths and types
    variable value codes and state word layout
    conflict analysis FSM states
*/
`default_nettype none

package sat_pkg;

    localparam int LVL_W = 4;
    localparam int BIN_W = 4;

    typedef logic [LVL_W-1:0] lvl_t;
    typedef logic [BIN_W-1:0] bin_id_t;
    typedef logic [1:0]       var_val_t;

    localparam var_val_t VAL_FREE  = 2'd0;
    localparam var_val_t VAL_FALSE = 2'd1;
    localparam var_val_t VAL_TRUE  = 2'd2;

    // flag | value | level
    typedef logic [6:0] var_state_t;

    localparam int VS_FLAG    = 6;
    localparam int VS_VAL_LSB = 4;
    localparam int VS_LVL_LSB = 0;

    typedef enum logic [2:0] {
        ANALYZE_IDLE = 3'd0,
        FIND_LEARNTC = 3'd1,
        ADD_LEARNTC  = 3'd2,
        ANALYZE_DONE = 3'd3,
        ANALYZE_WAIT = 3'd4
    } analyze_state_e;

endpackage

`default_nettype wire

//--- var_state_array.sv
/*
  per-variable state registers
    load, decision assignment, backtrack freeing
    free mask, learnt literals, max conflict level
*/
`timescale 1ns/1ps
`default_nettype none

module var_state_array #(
    parameter int NUM_VARS = 8
) (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire [NUM_VARS-1:0]                      wr_var_states_i,
    input  wire sat_pkg::var_state_t [NUM_VARS-1:0] var_states_i,
    input  wire [NUM_VARS-1:0]                      decided_onehot_i,
    input  wire sat_pkg::lvl_t                      cur_lvl_i,
    input  wire                                     apply_bkt_i,
    input  wire sat_pkg::lvl_t                      bkt_lvl_i,
    output sat_pkg::var_state_t [NUM_VARS-1:0]      var_states_o,
    output logic [NUM_VARS-1:0]                     free_mask_o,
    output logic [NUM_VARS-1:0]                     conflict_flags_o,
    output logic [2*NUM_VARS-1:0]                   learnt_lit_o,
    output sat_pkg::lvl_t                           max_lvl_o
);

    localparam int VAL_W = $bits(sat_pkg::var_val_t);

    sat_pkg::var_state_t [NUM_VARS-1:0] vs_q;
    sat_pkg::var_val_t                  val_w [NUM_VARS];
    sat_pkg::lvl_t                      lvl_w [NUM_VARS];
    sat_pkg::lvl_t                      next_lvl_w;

    assign next_lvl_w   = cur_lvl_i + sat_pkg::lvl_t'(1);
    assign var_states_o = vs_q;

    // field split of each word
    always_comb begin
        for (int i = 0; i < NUM_VARS; i++) begin
            val_w[i]            = vs_q[i][sat_pkg::VS_VAL_LSB +: VAL_W];
            lvl_w[i]            = vs_q[i][sat_pkg::VS_LVL_LSB +: sat_pkg::LVL_W];
            conflict_flags_o[i] = vs_q[i][sat_pkg::VS_FLAG];
            free_mask_o[i]      = (val_w[i] == sat_pkg::VAL_FREE);
        end
    end

    // load wins over decision, decision over backtrack
    always_ff @(posedge clk) begin
        if (!rst) begin
            vs_q <= '0;
        end else begin
            for (int i = 0; i < NUM_VARS; i++) begin
                if (wr_var_states_i[i]) begin
                    vs_q[i] <= var_states_i[i];
                end else if (decided_onehot_i[i]) begin
                    vs_q[i][sat_pkg::VS_VAL_LSB +: VAL_W]         <= sat_pkg::VAL_FALSE;
                    vs_q[i][sat_pkg::VS_LVL_LSB +: sat_pkg::LVL_W] <= next_lvl_w;
                end else if (apply_bkt_i) begin
                    vs_q[i][sat_pkg::VS_FLAG] <= 1'b0;
                    if (lvl_w[i] > bkt_lvl_i) begin
                        vs_q[i][sat_pkg::VS_VAL_LSB +: VAL_W]         <= sat_pkg::VAL_FREE;
                        vs_q[i][sat_pkg::VS_LVL_LSB +: sat_pkg::LVL_W] <= '0;
                    end
                end
            end
        end
    end

    // learnt literal is the negated value of each flagged variable
    always_comb begin
        max_lvl_o = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            learnt_lit_o[2*i +: 2] = '0;
            if (conflict_flags_o[i]) begin
                if (val_w[i] == sat_pkg::VAL_TRUE) begin
                    learnt_lit_o[2*i +: 2] = sat_pkg::VAL_FALSE;
                end else if (val_w[i] == sat_pkg::VAL_FALSE) begin
                    learnt_lit_o[2*i +: 2] = sat_pkg::VAL_TRUE;
                end
                // only assigned vars below the current level count
                if (val_w[i] != sat_pkg::VAL_FREE && lvl_w[i] < cur_lvl_i
                        && lvl_w[i] > max_lvl_o) begin
                    max_lvl_o = lvl_w[i];
                end
            end
        end
    end

    // decision unit assigns one variable at most
    a_decide_onehot: assert property (
        @(posedge clk) disable iff (!rst) $onehot0(decided_onehot_i)
    );

endmodule

`default_nettype wire

//--- lvl_state_array.sv
/*
  per-level bin id registers
    written on decision, cleared above the backtrack level
    bin lookup for the max conflict level
*/
`timescale 1ns/1ps
`default_nettype none

module lvl_state_array #(
    parameter int NUM_LVLS = 8
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              decide_en_i,
    input  wire sat_pkg::lvl_t               new_lvl_i,
    input  wire sat_pkg::bin_id_t            cur_bin_num_i,
    input  wire                              apply_bkt_i,
    input  wire sat_pkg::lvl_t               bkt_lvl_i,
    input  wire sat_pkg::lvl_t               max_lvl_i,
    output sat_pkg::bin_id_t [NUM_LVLS-1:0]  lvl_states_o,
    output sat_pkg::bin_id_t                 bin_at_max_o
);

    // entry k belongs to level k+1
    sat_pkg::bin_id_t [NUM_LVLS-1:0] bins_q;

    assign lvl_states_o = bins_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            bins_q <= '0;
        end else begin
            for (int k = 0; k < NUM_LVLS; k++) begin
                if (decide_en_i && new_lvl_i == sat_pkg::lvl_t'(k + 1)) begin
                    bins_q[k] <= cur_bin_num_i;
                end else if (apply_bkt_i && sat_pkg::lvl_t'(k + 1) > bkt_lvl_i) begin
                    bins_q[k] <= '0;
                end
            end
        end
    end

    // level 0 has no bin of its own
    always_comb begin
        bin_at_max_o = '0;
        for (int k = 0; k < NUM_LVLS; k++) begin
            if (max_lvl_i == sat_pkg::lvl_t'(k + 1)) begin
                bin_at_max_o = bins_q[k];
            end
        end
    end

    a_new_lvl_range: assert property (
        @(posedge clk) disable iff (!rst) decide_en_i |-> (new_lvl_i <= NUM_LVLS)
    );

endmodule

`default_nettype wire

//--- decision_unit.sv
/*
  current level register and decision logic
    lowest free variable pick
    decision and backtrack done pulses
*/
`timescale 1ns/1ps
`default_nettype none

module decision_unit #(
    parameter int NUM_VARS = 8
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 load_lvl_en_i,
    input  wire sat_pkg::lvl_t  load_lvl_i,
    input  wire                 start_decision_i,
    input  wire [NUM_VARS-1:0]  free_mask_i,
    input  wire                 apply_bkt_i,
    input  wire sat_pkg::lvl_t  bkt_lvl_i,
    output logic [NUM_VARS-1:0] decided_onehot_o,
    output logic                decide_en_o,
    output sat_pkg::lvl_t       new_lvl_o,
    output sat_pkg::lvl_t       cur_lvl_o,
    output logic                done_decision_o,
    output logic                done_bkt_o
);

    sat_pkg::lvl_t       cur_lvl_q;
    logic [NUM_VARS-1:0] pick_w;
    logic                any_free_w;

    // priority search from index 0
    always_comb begin
        logic found;
        found  = 1'b0;
        pick_w = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (free_mask_i[i] && !found) begin
                pick_w[i] = 1'b1;
                found     = 1'b1;
            end
        end
    end

    assign any_free_w       = |free_mask_i;
    assign decide_en_o      = start_decision_i & any_free_w;
    assign decided_onehot_o = start_decision_i ? pick_w : '0;
    assign new_lvl_o        = cur_lvl_q + sat_pkg::lvl_t'(1);
    assign cur_lvl_o        = cur_lvl_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cur_lvl_q <= '0;
        end else if (load_lvl_en_i) begin
            cur_lvl_q <= load_lvl_i;
        end else if (decide_en_o) begin
            cur_lvl_q <= new_lvl_o;
        end else if (apply_bkt_i) begin
            cur_lvl_q <= bkt_lvl_i;
        end
    end

    // done pulses one cycle after the request, even with nothing free
    always_ff @(posedge clk) begin
        if (!rst) begin
            done_decision_o <= 1'b0;
            done_bkt_o      <= 1'b0;
        end else begin
            done_decision_o <= start_decision_i;
            done_bkt_o      <= apply_bkt_i;
        end
    end

    a_no_decide_bkt: assert property (
        @(posedge clk) disable iff (!rst) !(start_decision_i && apply_bkt_i)
    );

endmodule

`default_nettype wire

//--- analyze_ctrl.sv
/*
  conflict analysis FSM
    settle check on the conflict flags
    learnt clause and done pulses
    backtrack level and bin registers
*/
`timescale 1ns/1ps
`default_nettype none

module analyze_ctrl #(
    parameter int NUM_VARS = 8
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    apply_analyze_i,
    input  wire [NUM_VARS-1:0]     conflict_flags_i,
    input  wire sat_pkg::lvl_t     max_lvl_i,
    input  wire sat_pkg::bin_id_t  bin_at_max_i,
    output logic                   add_learntc_en_o,
    output logic                   done_analyze_o,
    output sat_pkg::lvl_t          bkt_lvl_o,
    output sat_pkg::bin_id_t       bkt_bin_o
);

    sat_pkg::analyze_state_e state_q;
    sat_pkg::analyze_state_e state_d;
    logic [NUM_VARS-1:0]     flags_pre_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q     <= sat_pkg::ANALYZE_IDLE;
            flags_pre_q <= '0;
        end else begin
            state_q     <= state_d;
            flags_pre_q <= conflict_flags_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            sat_pkg::ANALYZE_IDLE: begin
                if (apply_analyze_i) begin
                    state_d = sat_pkg::FIND_LEARNTC;
                end
            end
            // wait for the flags to stop moving
            sat_pkg::FIND_LEARNTC: begin
                if (conflict_flags_i == flags_pre_q) begin
                    state_d = sat_pkg::ADD_LEARNTC;
                end
            end
            sat_pkg::ADD_LEARNTC:  state_d = sat_pkg::ANALYZE_DONE;
            sat_pkg::ANALYZE_DONE: state_d = sat_pkg::ANALYZE_WAIT;
            // controller drops the request once it has seen done
            sat_pkg::ANALYZE_WAIT: begin
                if (!apply_analyze_i) begin
                    state_d = sat_pkg::ANALYZE_IDLE;
                end
            end
            default: state_d = sat_pkg::ANALYZE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            add_learntc_en_o <= 1'b0;
            done_analyze_o   <= 1'b0;
            bkt_lvl_o        <= '0;
            bkt_bin_o        <= '0;
        end else begin
            add_learntc_en_o <= (state_q == sat_pkg::ADD_LEARNTC);
            done_analyze_o   <= (state_q == sat_pkg::ANALYZE_DONE);
            if (state_q == sat_pkg::ANALYZE_DONE) begin
                bkt_lvl_o <= max_lvl_i;
                bkt_bin_o <= bin_at_max_i;
            end
        end
    end

    a_learnt_then_done: assert property (
        @(posedge clk) disable iff (!rst) add_learntc_en_o |=> done_analyze_o
    );

endmodule

`default_nettype wire

//--- state_list.sv
/*
  state list top level
    variable and level state arrays
    decision unit and conflict analysis control
*/
`timescale 1ns/1ps
`default_nettype none

module state_list #(
    parameter int NUM_VARS = 8,
    parameter int NUM_LVLS = 8
) (
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire [NUM_VARS-1:0]                      wr_var_states_i,
    input  wire sat_pkg::var_state_t [NUM_VARS-1:0] var_states_i,
    output sat_pkg::var_state_t [NUM_VARS-1:0]      var_states_o,
    output logic [2*NUM_VARS-1:0]                   learnt_lit_o,
    input  wire                                     load_lvl_en_i,
    input  wire sat_pkg::lvl_t                      load_lvl_i,
    input  wire                                     start_decision_i,
    input  wire sat_pkg::bin_id_t                   cur_bin_num_i,
    output sat_pkg::lvl_t                           cur_lvl_o,
    output logic                                    done_decision_o,
    output logic                                    find_conflict_o,
    input  wire                                     apply_analyze_i,
    output logic                                    add_learntc_en_o,
    output logic                                    done_analyze_o,
    output sat_pkg::lvl_t                           bkt_lvl_o,
    output sat_pkg::bin_id_t                        bkt_bin_o,
    input  wire                                     apply_bkt_i,
    output logic                                    done_bkt_o,
    output sat_pkg::bin_id_t [NUM_LVLS-1:0]         lvl_states_o
);

    logic [NUM_VARS-1:0] decided_onehot;
    logic [NUM_VARS-1:0] free_mask;
    logic [NUM_VARS-1:0] conflict_flags;
    logic                decide_en;
    sat_pkg::lvl_t       new_lvl;
    sat_pkg::lvl_t       max_lvl;
    sat_pkg::bin_id_t    bin_at_max;

    assign find_conflict_o = |conflict_flags;

    var_state_array #(.NUM_VARS(NUM_VARS)) u_var_state_array (
        .clk              (clk),
        .rst              (rst),
        .wr_var_states_i  (wr_var_states_i),
        .var_states_i     (var_states_i),
        .decided_onehot_i (decided_onehot),
        .cur_lvl_i        (cur_lvl_o),
        .apply_bkt_i      (apply_bkt_i),
        .bkt_lvl_i        (bkt_lvl_o),
        .var_states_o     (var_states_o),
        .free_mask_o      (free_mask),
        .conflict_flags_o (conflict_flags),
        .learnt_lit_o     (learnt_lit_o),
        .max_lvl_o        (max_lvl)
    );

    lvl_state_array #(.NUM_LVLS(NUM_LVLS)) u_lvl_state_array (
        .clk           (clk),
        .rst           (rst),
        .decide_en_i   (decide_en),
        .new_lvl_i     (new_lvl),
        .cur_bin_num_i (cur_bin_num_i),
        .apply_bkt_i   (apply_bkt_i),
        .bkt_lvl_i     (bkt_lvl_o),
        .max_lvl_i     (max_lvl),
        .lvl_states_o  (lvl_states_o),
        .bin_at_max_o  (bin_at_max)
    );

    decision_unit #(.NUM_VARS(NUM_VARS)) u_decision_unit (
        .clk              (clk),
        .rst              (rst),
        .load_lvl_en_i    (load_lvl_en_i),
        .load_lvl_i       (load_lvl_i),
        .start_decision_i (start_decision_i),
        .free_mask_i      (free_mask),
        .apply_bkt_i      (apply_bkt_i),
        .bkt_lvl_i        (bkt_lvl_o),
        .decided_onehot_o (decided_onehot),
        .decide_en_o      (decide_en),
        .new_lvl_o        (new_lvl),
        .cur_lvl_o        (cur_lvl_o),
        .done_decision_o  (done_decision_o),
        .done_bkt_o       (done_bkt_o)
    );

    analyze_ctrl #(.NUM_VARS(NUM_VARS)) u_analyze_ctrl (
        .clk              (clk),
        .rst              (rst),
        .apply_analyze_i  (apply_analyze_i),
        .conflict_flags_i (conflict_flags),
        .max_lvl_i        (max_lvl),
        .bin_at_max_i     (bin_at_max),
        .add_learntc_en_o (add_learntc_en_o),
        .done_analyze_o   (done_analyze_o),
        .bkt_lvl_o        (bkt_lvl_o),
        .bkt_bin_o        (bkt_bin_o)
    );

endmodule

`default_nettype wire

//--- tb_state_list.sv
/*
  testbench for the state list
    reference model of variables, current level and bins
    rounds of load, decision, analysis and backtrack
*/
`timescale 1ns/1ps
`default_nettype none

module tb_state_list;

    localparam int NUM_VARS = 8;
    localparam int NUM_LVLS = 8;
    localparam int ROUNDS   = 3;
    // one round takes well under 100 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                                clk;
    logic                                rst;
    logic [NUM_VARS-1:0]                 wr_var_states_i;
    sat_pkg::var_state_t [NUM_VARS-1:0]  var_states_i;
    sat_pkg::var_state_t [NUM_VARS-1:0]  var_states_o;
    logic [2*NUM_VARS-1:0]               learnt_lit_o;
    logic                                load_lvl_en_i;
    sat_pkg::lvl_t                       load_lvl_i;
    logic                                start_decision_i;
    sat_pkg::bin_id_t                    cur_bin_num_i;
    sat_pkg::lvl_t                       cur_lvl_o;
    logic                                done_decision_o;
    logic                                find_conflict_o;
    logic                                apply_analyze_i;
    logic                                add_learntc_en_o;
    logic                                done_analyze_o;
    sat_pkg::lvl_t                       bkt_lvl_o;
    sat_pkg::bin_id_t                    bkt_bin_o;
    logic                                apply_bkt_i;
    logic                                done_bkt_o;
    sat_pkg::bin_id_t [NUM_LVLS-1:0]     lvl_states_o;

    // reference model with bin index k for level k+1
    sat_pkg::var_val_t model_val  [NUM_VARS];
    sat_pkg::lvl_t     model_lvl  [NUM_VARS];
    logic              model_flag [NUM_VARS];
    sat_pkg::bin_id_t  model_bin  [NUM_LVLS];
    sat_pkg::lvl_t     model_cur;

    integer seed;
    string  test_name;
    int     checks       = 0;
    int     errors       = 0;
    int     proto_errors = 0;
    int     cycles       = 0;

    state_list #(.NUM_VARS(NUM_VARS), .NUM_LVLS(NUM_LVLS)) UUT (
        .clk              (clk),
        .rst              (rst),
        .wr_var_states_i  (wr_var_states_i),
        .var_states_i     (var_states_i),
        .var_states_o     (var_states_o),
        .learnt_lit_o     (learnt_lit_o),
        .load_lvl_en_i    (load_lvl_en_i),
        .load_lvl_i       (load_lvl_i),
        .start_decision_i (start_decision_i),
        .cur_bin_num_i    (cur_bin_num_i),
        .cur_lvl_o        (cur_lvl_o),
        .done_decision_o  (done_decision_o),
        .find_conflict_o  (find_conflict_o),
        .apply_analyze_i  (apply_analyze_i),
        .add_learntc_en_o (add_learntc_en_o),
        .done_analyze_o   (done_analyze_o),
        .bkt_lvl_o        (bkt_lvl_o),
        .bkt_bin_o        (bkt_bin_o),
        .apply_bkt_i      (apply_bkt_i),
        .done_bkt_o       (done_bkt_o),
        .lvl_states_o     (lvl_states_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a done signal never arrived", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    a_decision_done: assert property (@(posedge clk) disable iff (!rst)
        done_decision_o == $past(start_decision_i))
        else begin
            proto_errors++;
            $display("done_decision_o did not pulse one cycle after start_decision_i");
        end

    a_bkt_done: assert property (@(posedge clk) disable iff (!rst)
        done_bkt_o == $past(apply_bkt_i))
        else begin
            proto_errors++;
            $display("done_bkt_o did not pulse one cycle after apply_bkt_i");
        end

    a_learnt_before_done: assert property (@(posedge clk) disable iff (!rst)
        done_analyze_o == $past(add_learntc_en_o))
        else begin
            proto_errors++;
            $display("done_analyze_o did not follow add_learntc_en_o by one cycle");
        end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_state();
        logic [1:0] lit;
        logic       any_flag;
        any_flag = 1'b0;
        for (int i = 0; i < NUM_VARS; i++) begin
            check_eq($sformatf("%s var %0d word", test_name, i),
                     {model_flag[i], model_val[i], model_lvl[i]}, var_states_o[i]);
            lit = 2'd0;
            if (model_flag[i] && model_val[i] == sat_pkg::VAL_TRUE) begin
                lit = sat_pkg::VAL_FALSE;
            end else if (model_flag[i] && model_val[i] == sat_pkg::VAL_FALSE) begin
                lit = sat_pkg::VAL_TRUE;
            end
            check_eq($sformatf("%s var %0d literal", test_name, i), lit,
                     learnt_lit_o[2*i +: 2]);
            any_flag = any_flag | model_flag[i];
        end
        for (int k = 0; k < NUM_LVLS; k++) begin
            check_eq($sformatf("%s bin of level %0d", test_name, k + 1), model_bin[k],
                     lvl_states_o[k]);
        end
        check_eq({test_name, " cur_lvl_o"}, model_cur, cur_lvl_o);
        check_eq({test_name, " find_conflict_o"}, any_flag, find_conflict_o);
    endtask

    function automatic int free_count();
        int n;
        n = 0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (model_val[i] == sat_pkg::VAL_FREE) begin
                n++;
            end
        end
        return n;
    endfunction

    // highest flagged assigned level below the current level
    function automatic sat_pkg::lvl_t max_conflict_lvl();
        sat_pkg::lvl_t m;
        m = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (model_flag[i] && model_val[i] != sat_pkg::VAL_FREE
                    && model_lvl[i] < model_cur && model_lvl[i] > m) begin
                m = model_lvl[i];
            end
        end
        return m;
    endfunction

    task automatic write_words(input logic [NUM_VARS-1:0] mask,
                               input sat_pkg::var_state_t [NUM_VARS-1:0] words);
        @(posedge clk);
        wr_var_states_i <= mask;
        var_states_i    <= words;
        @(posedge clk);
        wr_var_states_i <= '0;
        @(negedge clk);
    endtask

    task automatic set_level(input sat_pkg::lvl_t lvl);
        @(posedge clk);
        load_lvl_en_i <= 1'b1;
        load_lvl_i    <= lvl;
        @(posedge clk);
        load_lvl_en_i <= 1'b0;
        @(negedge clk);
        model_cur = lvl;
        check_eq({test_name, " loaded level"}, lvl, cur_lvl_o);
    endtask

    task automatic decide();
        sat_pkg::bin_id_t bin;
        int               pick;
        bin = sat_pkg::bin_id_t'($random(seed));
        @(posedge clk);
        start_decision_i <= 1'b1;
        cur_bin_num_i    <= bin;
        @(posedge clk);
        start_decision_i <= 1'b0;
        @(negedge clk);
        while (!done_decision_o) @(negedge clk);
        pick = -1;
        for (int i = NUM_VARS - 1; i >= 0; i--) begin
            if (model_val[i] == sat_pkg::VAL_FREE) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            model_cur = model_cur + 1'b1;
            model_val[pick] = sat_pkg::VAL_FALSE;
            model_lvl[pick] = model_cur;
            model_bin[int'(model_cur) - 1] = bin;
        end
        check_state();
    endtask

    task automatic run_round();
        sat_pkg::var_state_t [NUM_VARS-1:0] words;
        logic [NUM_VARS-1:0]                mask;
        logic [31:0]                        r;
        sat_pkg::lvl_t                      exp_lvl;
        sat_pkg::bin_id_t                   exp_bin;
        // vars 0 and 5 always pre-assigned so decisions stay within NUM_LVLS
        test_name = "load";
        for (int i = 0; i < NUM_VARS; i++) begin
            r = $random(seed);
            if (r[0] || i == 0 || i == 5) begin
                model_val[i] = r[1] ? sat_pkg::VAL_TRUE : sat_pkg::VAL_FALSE;
                model_lvl[i] = r[2] ? 4'd2 : 4'd1;
            end else begin
                model_val[i] = sat_pkg::VAL_FREE;
                model_lvl[i] = '0;
            end
            model_flag[i] = 1'b0;
            words[i] = {1'b0, model_val[i], model_lvl[i]};
        end
        write_words('1, words);
        set_level(4'd2);
        check_state();
        test_name = "decision";
        while (free_count() > 0) decide();
        test_name = "decision none free";
        decide();
        // top level variables drop out of the max level search
        test_name = "load level";
        set_level(model_cur - 1'b1);
        test_name = "conflict";
        mask = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            r = $random(seed);
            words[i] = '0;
            if (model_val[i] != sat_pkg::VAL_FREE && (r[0] || i == 0)) begin
                model_flag[i] = 1'b1;
                mask[i] = 1'b1;
                words[i] = {1'b1, model_val[i], model_lvl[i]};
            end
        end
        write_words(mask, words);
        check_state();
        test_name = "analysis";
        exp_lvl = max_conflict_lvl();
        exp_bin = (exp_lvl == 0) ? '0 : model_bin[int'(exp_lvl) - 1];
        @(posedge clk);
        apply_analyze_i <= 1'b1;
        @(negedge clk);
        while (!done_analyze_o) @(negedge clk);
        check_eq({test_name, " bkt_lvl_o"}, exp_lvl, bkt_lvl_o);
        check_eq({test_name, " bkt_bin_o"}, exp_bin, bkt_bin_o);
        @(posedge clk);
        apply_analyze_i <= 1'b0;
        @(negedge clk);
        test_name = "backtrack";
        @(posedge clk);
        apply_bkt_i <= 1'b1;
        @(posedge clk);
        apply_bkt_i <= 1'b0;
        @(negedge clk);
        while (!done_bkt_o) @(negedge clk);
        for (int i = 0; i < NUM_VARS; i++) begin
            model_flag[i] = 1'b0;
            if (model_lvl[i] > exp_lvl) begin
                model_val[i] = sat_pkg::VAL_FREE;
                model_lvl[i] = '0;
            end
        end
        for (int k = 0; k < NUM_LVLS; k++) begin
            if (k + 1 > int'(exp_lvl)) begin
                model_bin[k] = '0;
            end
        end
        model_cur = exp_lvl;
        check_state();
    endtask

    initial begin
        seed             = 32'h67c8_2073;
        rst              = 1'b0;
        wr_var_states_i  = '0;
        var_states_i     = '0;
        load_lvl_en_i    = 1'b0;
        load_lvl_i       = '0;
        start_decision_i = 1'b0;
        cur_bin_num_i    = '0;
        apply_analyze_i  = 1'b0;
        apply_bkt_i      = 1'b0;
        for (int i = 0; i < NUM_VARS; i++) begin
            model_val[i]  = sat_pkg::VAL_FREE;
            model_lvl[i]  = '0;
            model_flag[i] = 1'b0;
        end
        for (int k = 0; k < NUM_LVLS; k++) begin
            model_bin[k] = '0;
        end
        model_cur = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        test_name = "reset";
        check_state();
        check_eq("reset done_decision_o", 0, done_decision_o);
        check_eq("reset done_analyze_o", 0, done_analyze_o);
        check_eq("reset add_learntc_en_o", 0, add_learntc_en_o);
        check_eq("reset done_bkt_o", 0, done_bkt_o);
        check_eq("reset bkt_lvl_o", 0, bkt_lvl_o);
        check_eq("reset bkt_bin_o", 0, bkt_bin_o);
        for (int n = 0; n < ROUNDS; n++) begin
            run_round();
        end
        @(negedge clk);
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
sat_pkg.sv
var_state_array.sv
lvl_state_array.sv
decision_unit.sv
analyze_ctrl.sv
state_list.sv
tb_state_list.sv

//--- run.sh
#!/bin/sh
# build and run the state list testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_state_list -f sim.f -o tb_state_list
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_state_list)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
